//--- filelist.f
+incdir+src
src/backup_pkg.sv
src/bk_media_policy.sv
src/bk_sequencer.sv
src/bk_sector_counter.sv
src/bk_format_writer.sv
src/bk_ram.sv
src/backup_ram_top.sv
dv/backup_ram_sva.sv
dv/backup_ram_tb.sv

//--- dv/backup_ram_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the backup RAM subsystem
// Host model serves the strobes from a 1 K word image, one transfer at a time
// Inputs change and outputs are sampled 1 ns after the rising edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "backup_config.svh"

module backup_ram_tb;

	localparam int IMG_WORDS = `BK_SECTORS * `BK_SECTOR_WORDS;
	localparam int XFERS     = 3;   // Download load, manual save, autosave
	localparam int LIMIT_NS  = 8 * (XFERS * IMG_WORDS + 4 * (1 << `BK_BYTE_AW) + 2000);

	logic                                clk_sys = 1'b0;
	logic                                reset = 1'b1;
	logic [`BK_BYTE_AW-1:0]              bram_addr = '0;
	logic [7:0]                          bram_data = '0;
	logic [7:0]                          bram_q;
	logic [1:0]                          sd_lba;
	logic [$clog2(`BK_SECTOR_WORDS)-1:0] sd_buff_addr = '0;
	logic [15:0]                         sd_buff_dout = '0;
	logic [15:0]                         sd_buff_din;
	logic                                bram_wr = 1'b0, sd_ack = 1'b0, sd_buff_wr = 1'b0;
	logic                                img_mounted = 1'b0, img_readonly = 1'b0;
	logic                                downloading = 1'b0, osd_status = 1'b0;
	logic                                autosave = 1'b0, format = 1'b0;
	logic                                bk_load = 1'b0, bk_save = 1'b0;
	logic                                sd_rd, sd_wr, bk_ena, bk_busy, bk_loading, bk_pending;

	logic [15:0] image [0:IMG_WORDS-1];   // Host copy of the save image
	logic [15:0] model [0:IMG_WORDS-1];   // What the backup memory should hold
	logic [15:0] saved [0:IMG_WORDS-1];
	logic [26:0] steps [0:7];             // {address, data, expected readback}
	logic [15:0] lfsr = 16'd28;
	int          errors = 0;
	int          checks = 0;

	backup_ram_top uut (.*);

	always #4 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	task automatic draw(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[14:0], lfsr[0]};   // One step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic write_byte(input logic [`BK_BYTE_AW-1:0] a, input logic [7:0] d);
		bram_addr = a;
		bram_data = d;
		bram_wr   = 1'b1;
		tick();
		bram_wr = 1'b0;
		if (a[0])
			model[a >> 1][15:8] = d;   // Odd byte is the high half
		else
			model[a >> 1][7:0] = d;
	endtask

	task automatic read_byte(input logic [`BK_BYTE_AW-1:0] a, output logic [7:0] q);
		bram_addr = a;
		tick();
		q = bram_q;
	endtask

	// One whole transfer, a load sends image words and a save captures them
	task automatic serve_host(input logic is_load);
		logic [15:0] gap;
		int          base;
		for (int s = 0; s < `BK_SECTORS; s++) begin
			while (!(sd_rd || sd_wr))
				tick();
			check_value("sd_lba", sd_lba, s);
			check_value("sd_rd", sd_rd, is_load);
			check_value("sd_wr", sd_wr, !is_load);
			check_value("bk_loading", bk_loading, is_load);
			draw(3, gap);   // Host latency 0..7 cycles
			repeat (gap) tick();
			sd_ack = 1'b1;
			base   = s * `BK_SECTOR_WORDS;
			for (int i = 0; i < `BK_SECTOR_WORDS; i++) begin
				sd_buff_addr = i;
				sd_buff_dout = image[base + i];
				sd_buff_wr   = is_load;
				tick();
				if (!is_load)
					saved[base + i] = sd_buff_din;   // Word of the address one cycle back
			end
			sd_ack     = 1'b0;
			sd_buff_wr = 1'b0;
			tick();
		end
		while (bk_busy)
			tick();
	endtask

	task automatic compare_saved();
		for (int w = 0; w < IMG_WORDS; w++) begin
			check_value("sd_buff_din", saved[w], model[w]);
			image[w] = saved[w];
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [7:0]  q;
		logic [15:0] hdr [0:3];
		hdr = '{`BK_HDR_0, `BK_HDR_1, `BK_HDR_2, `BK_HDR_3};
		steps[0] = {11'h000, 8'h5A, 8'h5A};
		steps[1] = {11'h001, 8'hA5, 8'hA5};
		steps[2] = {11'h155, 8'h3C, 8'h3C};
		steps[3] = {11'h2AA, 8'hC3, 8'hC3};
		steps[4] = {11'h400, 8'h01, 8'h01};
		steps[5] = {11'h401, 8'hFE, 8'hFE};
		steps[6] = {11'h7FE, 8'h77, 8'h77};
		steps[7] = {11'h7FE, 8'h88, 8'h88};   // Overwrites the step before
		for (int w = 0; w < IMG_WORDS; w++) begin
			draw(16, image[w]);
			model[w] = image[w];
		end
		repeat (16) tick();
		reset = 1'b0;
		check_value("bk_busy", bk_busy, 0);
		check_value("bk_loading", bk_loading, 0);
		check_value("sd_rd", sd_rd, 0);
		check_value("sd_wr", sd_wr, 0);
		check_value("bk_ena", bk_ena, 0);
		check_value("bk_pending", bk_pending, 0);

		// Writable image mounted during the download, load at its end
		downloading = 1'b1;
		tick();
		img_mounted = 1'b1;
		tick();
		img_mounted = 1'b0;
		tick();
		check_value("bk_ena", bk_ena, 1);
		downloading = 1'b0;
		serve_host(1'b1);
		for (int a = 0; a < 2 * IMG_WORDS; a++) begin
			read_byte(a, q);
			check_value("bram_q", q, a[0] ? image[a / 2][15:8] : image[a / 2][7:0]);
		end

		for (int n = 0; n < 8; n++) begin
			write_byte(steps[n][26:16], steps[n][15:8]);
			read_byte(steps[n][26:16], q);
			check_value("bram_q", q, steps[n][7:0]);
		end
		check_value("bk_pending", bk_pending, 1);
		bk_save = 1'b1;
		tick();
		bk_save = 1'b0;
		serve_host(1'b0);
		compare_saved();
		check_value("bk_pending", bk_pending, 0);

		// Autosave when the menu opens, no bk_save edge
		write_byte(11'h3FF, 8'h96);
		check_value("bk_pending", bk_pending, 1);
		autosave   = 1'b1;
		osd_status = 1'b1;
		serve_host(1'b0);
		compare_saved();
		check_value("bk_pending", bk_pending, 0);
		osd_status = 1'b0;
		autosave   = 1'b0;

		format = 1'b1;
		tick();
		format = 1'b0;
		repeat (5) tick();   // Header lands on four cycles after the edge
		for (int a = 0; a < 8; a++) begin
			read_byte(a, q);
			check_value("bram_q", q, a[0] ? hdr[a / 2][15:8] : hdr[a / 2][7:0]);
		end

		// Read-only image keeps the backup off
		downloading = 1'b1;
		tick();
		img_mounted  = 1'b1;
		img_readonly = 1'b1;
		tick();
		img_mounted = 1'b0;
		downloading = 1'b0;
		repeat (2) tick();
		check_value("bk_ena", bk_ena, 0);
		repeat (2) begin
			bk_load = 1'b1;
			tick();
			bk_load = 1'b0;
			repeat (16) begin
				tick();
				check_value("bk_busy", bk_busy, 0);
				check_value("sd_rd", sd_rd, 0);
			end
		end

		$display("Checks %0d, errors %0d, assertion failures %0d",
			checks, errors, uut.u_seq.seq_sva.fail_count);
		if (errors == 0 && uut.u_seq.seq_sva.fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		#(LIMIT_NS);
		$display("Timeout, the tests did not finish within %0d ns", LIMIT_NS);
		$display("Checks %0d, errors %0d", checks, errors);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- dv/backup_ram_sva.sv
////////////////////////////////////////////////////////////////////////////
// Strobe and state checks on the load/save sequencer
// Bound to every bk_sequencer, checks are off while reset is high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "backup_config.svh"

module backup_ram_sva (
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  sd_ack,
	input logic                  sd_rd,
	input logic                  sd_wr,
	input logic                  bk_busy,
	input logic                  bk_loading,
	input backup_pkg::bk_state_t state
);

	import backup_pkg::*;

	int fail_count = 0;   // Read by the testbench at the end

	task automatic report_fail(input string what);
		$error("%s", what);
		fail_count++;
	endtask

	a_one_strobe: assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else report_fail("sd_rd and sd_wr high together");

	// Host saw the request, strobe goes away on the next edge
	a_strobe_drop: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_ack) |=> !sd_rd && !sd_wr)
		else report_fail("strobe still high one cycle after sd_ack rose");

	a_strobe_busy: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> bk_busy)
		else report_fail("strobe high while the sequencer is idle");

	a_direction: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd |-> state == BK_LOAD) and (sd_wr |-> state == BK_SAVE))
		else report_fail("strobe does not match the transfer direction");

	// Next sector is only requested once the host has let go of sd_ack
	a_strobe_rise: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(sd_rd) || $rose(sd_wr)) |-> !$past(sd_ack))
		else report_fail("strobe raised while sd_ack was still high");

endmodule

// Attach to the sequencer inside the DUT
bind bk_sequencer backup_ram_sva seq_sva (.*);

//--- src/backup_ram_top.sv
////////////////////////////////////////////////////////////////////////////
// Backup RAM save and load subsystem
// Everything runs on clk_sys with a synchronous active-high reset
// Host must follow the rd/wr strobe and sd_ack level protocol
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "backup_config.svh"

module backup_ram_top (
	input  logic                                clk_sys,
	input  logic                                reset,

	// Console port
	input  logic [`BK_BYTE_AW-1:0]              bram_addr,
	input  backup_pkg::bk_byte_t                bram_data,
	input  logic                                bram_wr,
	output backup_pkg::bk_byte_t                bram_q,

	// Host block port
	output backup_pkg::bk_lba_t                 sd_lba,
	output logic                                sd_rd,
	output logic                                sd_wr,
	input  logic                                sd_ack,
	input  logic [$clog2(`BK_SECTOR_WORDS)-1:0] sd_buff_addr,
	input  backup_pkg::bk_word_t                sd_buff_dout,
	output backup_pkg::bk_word_t                sd_buff_din,
	input  logic                                sd_buff_wr,

	// Control
	input  logic                                img_mounted,
	input  logic                                img_readonly,
	input  logic                                downloading,
	input  logic                                osd_status,
	input  logic                                bk_load,
	input  logic                                bk_save,
	input  logic                                autosave,
	input  logic                                format,

	// Status
	output logic                                bk_ena,
	output logic                                bk_busy,
	output logic                                bk_loading,
	output logic                                bk_pending
);

	import backup_pkg::*;

	logic     save_req;
	logic     dl_load;
	logic     start_xfer;
	logic     sector_done;
	logic     last_sector;
	logic     fmt_we;
	logic [1:0] fmt_addr;
	bk_word_t fmt_data;

	bk_media_policy u_policy (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.downloading (downloading),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.osd_status  (osd_status),
		.autosave    (autosave),
		.bk_save     (bk_save),
		.bram_wr     (bram_wr),
		.bk_busy     (bk_busy),
		.bk_ena      (bk_ena),
		.bk_pending  (bk_pending),
		.save_req    (save_req),
		.dl_load     (dl_load)
	);

	bk_sequencer u_seq (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bk_ena     (bk_ena),
		.bk_load    (bk_load),
		.save_req   (save_req),
		.dl_load    (dl_load),
		.sd_ack     (sd_ack),
		.sector_done(sector_done),
		.last_sector(last_sector),
		.bk_busy    (bk_busy),
		.bk_loading (bk_loading),
		.start_xfer (start_xfer),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr)
	);

	bk_sector_counter u_cnt (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.start_xfer (start_xfer),
		.sd_ack     (sd_ack),
		.sd_lba     (sd_lba),
		.sector_done(sector_done),
		.last_sector(last_sector)
	);

	bk_format_writer u_fmt (
		.clk_sys (clk_sys),
		.reset   (reset),
		.format  (format),
		.fmt_we  (fmt_we),
		.fmt_addr(fmt_addr),
		.fmt_data(fmt_data)
	);

	bk_ram u_ram (
		.clk_sys     (clk_sys),
		.bram_addr   (bram_addr),
		.bram_data   (bram_data),
		.bram_wr     (bram_wr),
		.sd_lba      (sd_lba),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr  (sd_buff_wr),
		.sd_ack      (sd_ack),
		.fmt_we      (fmt_we),
		.fmt_addr    (fmt_addr),
		.fmt_data    (fmt_data),
		.bram_q      (bram_q),
		.sd_buff_din (sd_buff_din)
	);

endmodule

//--- src/bk_ram.sv
////////////////////////////////////////////////////////////////////////////
// 2 KB backup memory, byte port for the console, word port for the host
// Both ports read with one cycle of latency, old data on a write
// Formatter owns the word port while it runs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "backup_config.svh"

module bk_ram (
	input  logic                                   clk_sys,
	input  logic [`BK_BYTE_AW-1:0]                 bram_addr,
	input  backup_pkg::bk_byte_t                   bram_data,
	input  logic                                   bram_wr,
	input  backup_pkg::bk_lba_t                    sd_lba,
	input  logic [$clog2(`BK_SECTOR_WORDS)-1:0]    sd_buff_addr,
	input  backup_pkg::bk_word_t                   sd_buff_dout,
	input  logic                                   sd_buff_wr,
	input  logic                                   sd_ack,
	input  logic                                   fmt_we,
	input  logic [1:0]                             fmt_addr,
	input  backup_pkg::bk_word_t                   fmt_data,
	output backup_pkg::bk_byte_t                   bram_q,
	output backup_pkg::bk_word_t                   sd_buff_din
);

	import backup_pkg::*;

	bk_word_t mem [0:(1 << `BK_WORD_AW)-1];

	logic [`BK_WORD_AW-1:0] word_a;
	bk_word_t               q_a;
	logic                   hi_a;

	logic [`BK_WORD_AW-1:0] addr_b;
	bk_word_t               data_b;
	logic                   we_b;

	////////////////////////////////////////////////////////////////////////////
	// Console port, even byte is the low half of the word
	assign word_a = bram_addr[`BK_BYTE_AW-1:1];

	always @(posedge clk_sys) begin
		if (bram_wr) begin
			if (bram_addr[0])
				mem[word_a][15:8] <= bram_data;
			else
				mem[word_a][7:0] <= bram_data;
		end
		q_a  <= mem[word_a];
		hi_a <= bram_addr[0];
	end

	assign bram_q = hi_a ? q_a[15:8] : q_a[7:0];

	////////////////////////////////////////////////////////////////////////////
	// Host port
	assign addr_b = fmt_we ? {{(`BK_WORD_AW-2){1'b0}}, fmt_addr} : {sd_lba, sd_buff_addr};
	assign data_b = fmt_we ? fmt_data : sd_buff_dout;
	assign we_b   = fmt_we | (sd_buff_wr & sd_ack);   // Stray writes outside a transfer ignored

	always @(posedge clk_sys) begin
		if (we_b)
			mem[addr_b] <= data_b;
		sd_buff_din <= mem[addr_b];
	end

endmodule

//--- src/bk_format_writer.sv
////////////////////////////////////////////////////////////////////////////
// Writes the default header into word addresses 0..3
// One word per cycle, starting the cycle after the format edge
// Rest of the memory is left as it is
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "backup_config.svh"

module bk_format_writer (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 format,
	output logic                 fmt_we,
	output logic [1:0]           fmt_addr,
	output backup_pkg::bk_word_t fmt_data
);

	logic old_fmt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_fmt  <= 1'b0;
			fmt_we   <= 1'b0;
			fmt_addr <= 2'd0;
		end else begin
			old_fmt <= format;

			if (~old_fmt & format) begin
				fmt_we   <= 1'b1;
				fmt_addr <= 2'd0;
			end else if (fmt_we) begin
				if (fmt_addr == 2'd3)
					fmt_we <= 1'b0;   // Fourth word done
				fmt_addr <= fmt_addr + 2'd1;
			end
		end
	end

	// Header word for the current step
	always_comb begin
		case (fmt_addr)
			2'd0:    fmt_data = `BK_HDR_0;
			2'd1:    fmt_data = `BK_HDR_1;
			2'd2:    fmt_data = `BK_HDR_2;
			default: fmt_data = `BK_HDR_3;
		endcase
	end

endmodule

//--- src/bk_sector_counter.sv
////////////////////////////////////////////////////////////////////////////
// Sector index of the running transfer
// Index advances on each sd_ack fall except after the last sector
// last_sector tells that the sector just finished was the final one
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "backup_config.svh"

module bk_sector_counter (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                start_xfer,
	input  logic                sd_ack,
	output backup_pkg::bk_lba_t sd_lba,
	output logic                sector_done,
	output logic                last_sector
);

	import backup_pkg::*;

	localparam bk_lba_t LAST_LBA = bk_lba_t'(`BK_SECTORS - 1);

	logic old_ack;
	logic ack_fall;

	assign ack_fall = old_ack & ~sd_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_ack     <= 1'b0;
			sd_lba      <= '0;
			sector_done <= 1'b0;
			last_sector <= 1'b0;
		end else begin
			old_ack     <= sd_ack;
			sector_done <= ack_fall;   // Seen by the sequencer one cycle after the fall

			if (start_xfer) begin
				sd_lba      <= '0;
				last_sector <= 1'b0;
			end else if (ack_fall) begin
				if (sd_lba == LAST_LBA)
					last_sector <= 1'b1;
				else
					sd_lba <= sd_lba + 1'b1;
			end
		end
	end

endmodule

//--- src/bk_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Load and save sequencer for the host block port
// Requests are edge-detected, anything arriving while busy is dropped
// Waits for sd_ack without any timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bk_sequencer (
	input  logic clk_sys,
	input  logic reset,
	input  logic bk_ena,
	input  logic bk_load,
	input  logic save_req,
	input  logic dl_load,
	input  logic sd_ack,
	input  logic sector_done,
	input  logic last_sector,
	output logic bk_busy,
	output logic bk_loading,
	output logic start_xfer,
	output logic sd_rd,
	output logic sd_wr
);

	import backup_pkg::*;

	bk_state_t state;

	logic old_load;
	logic old_save;
	logic old_ack;
	logic load_go;
	logic save_go;

	// Load wins when both edges land together
	assign load_go = bk_ena & ((~old_load & bk_load) | dl_load);
	assign save_go = bk_ena & ~old_save & save_req & ~load_go;

	assign start_xfer = (state == BK_IDLE) & (load_go | save_go);
	assign bk_busy    = (state != BK_IDLE);
	assign bk_loading = (state == BK_LOAD);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= BK_IDLE;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= save_req;
			old_ack  <= sd_ack;

			// Host took the request
			if (~old_ack & sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (load_go) begin
						state <= BK_LOAD;
						sd_rd <= 1'b1;
						sd_wr <= 1'b0;
					end else if (save_go) begin
						state <= BK_SAVE;
						sd_rd <= 1'b0;
						sd_wr <= 1'b1;
					end
				end
				default: begin
					if (sector_done) begin
						if (last_sector) begin
							state <= BK_IDLE;
						end else begin
							sd_rd <= (state == BK_LOAD);   // Next sector, same direction
							sd_wr <= (state == BK_SAVE);
						end
					end
				end
			endcase
		end
	end

endmodule

//--- src/bk_media_policy.sv
////////////////////////////////////////////////////////////////////////////
// Backup enable, pending writes and request forming
// The save image is expected to be mounted while downloading is high
// A read-only image leaves the backup disabled until the next download
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bk_media_policy (
	input  logic clk_sys,
	input  logic reset,
	input  logic downloading,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic osd_status,
	input  logic autosave,
	input  logic bk_save,
	input  logic bram_wr,
	input  logic bk_busy,
	output logic bk_ena,
	output logic bk_pending,
	output logic save_req,
	output logic dl_load
);

	logic old_dl;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_dl     <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			old_dl <= downloading;

			// New cartridge, forget the old image
			if (~old_dl & downloading)
				bk_ena <= 1'b0;
			if (downloading & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;

			// Console wrote something the image does not have yet
			if (bk_ena & ~osd_status & bram_wr)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// Manual save, or autosave once the menu opens
	assign save_req = bk_save | (bk_pending & osd_status & autosave);

	// Load the image right after the download ends
	assign dl_load = old_dl & ~downloading & bk_ena;

endmodule

//--- src/backup_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the backup RAM subsystem
// Sector index width follows the sector count of the config header
////////////////////////////////////////////////////////////////////////////

`include "backup_config.svh"

package backup_pkg;

	// Transfer sequencer states
	typedef enum logic [1:0] {
		BK_IDLE = 2'd0,
		BK_LOAD = 2'd1,   // Image to memory
		BK_SAVE = 2'd2    // Memory to image
	} bk_state_t;

	// Sector index within the image
	typedef logic [$clog2(`BK_SECTORS)-1:0] bk_lba_t;

	// Host block port word
	typedef logic [15:0] bk_word_t;

	// Console port byte
	typedef logic [7:0] bk_byte_t;

endpackage

//--- src/backup_config.svh
////////////////////////////////////////////////////////////////////////////
// Sizes of the backup memory and the save image layout
// Image is always four 512-byte sectors, no second sector range
// Header words are what a freshly formatted backup RAM holds
////////////////////////////////////////////////////////////////////////////

`ifndef BACKUP_CONFIG_SVH
`define BACKUP_CONFIG_SVH

// Image geometry
`define BK_SECTORS       4
`define BK_SECTOR_WORDS  256

// Address widths
`define BK_BYTE_AW       11   // Console side, 2 KB bytewise
`define BK_WORD_AW       10   // Host side, 1 K words

// Default header written by format
`define BK_HDR_0         16'h5548
`define BK_HDR_1         16'h4D42
`define BK_HDR_2         16'h8800
`define BK_HDR_3         16'h8010

`endif
